//--- include/udp_tx_tests.svh
`ifndef UDP_TX_TESTS_SVH
`define UDP_TX_TESTS_SVH

// Ones-complement sum of the IPv4 header with a zero checksum field
function automatic csum_t ip_header_checksum(input len_t total_len);
  logic [31:0] sum;
  sum = 32'(IP_VER_TOS) + 32'(total_len) + 32'(IP_ID) + 32'(IP_FLAGS) + 32'(IP_TTL_PROTO)
      + 32'(IP_SRC_HI) + 32'(IP_SRC_LO) + 32'(IP_DST_HI) + 32'(IP_DST_LO);
  while (sum[31:16] != 0) begin
    sum = 32'(sum[31:16]) + 32'(sum[15:0]);  // Fold carries back in
  end
  return ~sum[15:0];
endfunction

task automatic push_low_lane_first(input st_data_t w);
  for (int b = 0; b < 4; b++) begin
    wire_bytes.push_back(w[8*b +: 8]);
  end
endtask

// Frame built as wire bytes and packed with first byte in MSBs
task automatic build_expected_frame(input mtu_t m, input sample_t spd, input sample_t adc);
  len_t       total_len;
  len_t       udp_len;
  logic [15:0] halves [14];
  total_len = len_t'(m) + len_t'(IP_HDR_BYTES + UDP_HDR_BYTES);
  udp_len   = len_t'(m) + len_t'(UDP_HDR_BYTES);
  wire_bytes.delete();
  exp_words.delete();
  for (int i = 0; i < LINK_WORDS; i++) begin
    push_low_lane_first(LINK_HEADER_WORDS[i]);
  end
  halves = '{IP_VER_TOS, total_len, IP_ID, IP_FLAGS, IP_TTL_PROTO,
             ip_header_checksum(total_len), IP_SRC_HI, IP_SRC_LO, IP_DST_HI, IP_DST_LO,
             UDP_SRC_PORT, UDP_DST_PORT, udp_len, 16'h0000};
  foreach (halves[i]) begin
    wire_bytes.push_back(halves[i][15:8]);  // Network order
    wire_bytes.push_back(halves[i][7:0]);
  end
  for (int i = 0; i < int'(m) / 4; i++) begin
    push_low_lane_first({spd, adc});
  end
  for (int i = 0; i + 3 < wire_bytes.size(); i += 4) begin
    exp_words.push_back({wire_bytes[i], wire_bytes[i+1], wire_bytes[i+2], wire_bytes[i+3]});
  end
endtask

task automatic start_frame(input mtu_t m, input sample_t spd, input sample_t adc);
  @(posedge Clock_xCI);
  mtu          <= m;
  speed_sample <= spd;
  adc_sample   <= adc;
  repeat (8) @(posedge Clock_xCI);  // Lengths and checksum settle
  send_packet <= 1'b1;
  @(posedge Clock_xCI);
  send_packet <= 1'b0;
endtask

// Collect one frame up to eop
// Nonzero pulse_at raises send_packet mid-frame
task automatic receive_frame(input int pulse_at, output int busy);
  int   cycles;
  logic seen_eop;
  cycles   = 0;
  busy     = 0;
  seen_eop = 1'b0;
  got_words.delete();
  while (!seen_eop && cycles < FRAME_TIMEOUT) begin
    @(posedge Clock_xCI);
    cycles++;
    if (st_valid || got_words.size() > 0) busy++;  // Cycles since first valid
    if (st_valid && st_ready) begin
      checks++;
      if (st_sop !== (got_words.size() == 0)) begin
        errors++;
        $display("FAIL st_sop word %0d got %h expected %h", got_words.size(), st_sop,
                 got_words.size() == 0);
      end
      got_words.push_back(st_data);
      seen_eop = st_eop;
    end
    send_packet <= (pulse_at > 0 && got_words.size() == pulse_at);
  end
  send_packet <= 1'b0;
  if (!seen_eop) begin
    errors++;
    $display("No end of frame within %0d cycles", FRAME_TIMEOUT);
  end
endtask

task automatic check_frame(input mtu_t m, input sample_t spd, input sample_t adc);
  build_expected_frame(m, spd, adc);
  checks++;
  if (got_words.size() != exp_words.size()) begin
    errors++;
    $display("FAIL frame word count got %h expected %h", got_words.size(), exp_words.size());
  end
  for (int i = 0; i < got_words.size() && i < exp_words.size(); i++) begin
    checks++;
    if (got_words[i] !== exp_words[i]) begin
      errors++;
      $display("FAIL st_data word %0d got %h expected %h", i, got_words[i], exp_words[i]);
    end
  end
endtask

// With ready high a frame takes one cycle per word
task automatic check_frame_cycles(input int busy, input int expected);
  checks++;
  if (busy != expected) begin
    errors++;
    $display("FAIL frame cycles got %h expected %h", busy, expected);
  end
endtask

task automatic expect_no_frame(input int n);
  repeat (n) begin
    @(posedge Clock_xCI);
    checks++;
    if (st_valid !== 1'b0) begin
      errors++;
      $display("FAIL st_valid got %h expected %h", st_valid, 1'b0);
    end
  end
endtask

task automatic verify_init_writes();
  int wait_cycles;
  wait_cycles = 0;
  @(posedge Clock_xCI);
  send_packet <= 1'b1;  // Early request before init_done
  @(posedge Clock_xCI);
  send_packet <= 1'b0;
  while (!init_done && wait_cycles < INIT_TIMEOUT) begin
    @(posedge Clock_xCI);
    wait_cycles++;
  end
  checks++;
  if (!init_done) begin
    errors++;
    $display("init_done did not rise within %0d cycles", INIT_TIMEOUT);
  end else if (writes_seen != INIT_ENTRIES + 1) begin
    errors++;
    $display("FAIL writes_seen got %h expected %h", writes_seen, INIT_ENTRIES + 1);
  end
  expect_no_frame(2 * HDR_WORDS);
endtask

task automatic single_frame_ready_high();
  int busy;
  start_frame(16'd8, 16'h1234, 16'hABCD);
  receive_frame(0, busy);
  check_frame(16'd8, 16'h1234, 16'hABCD);
  check_frame_cycles(busy, HDR_WORDS + 2);
  if (got_words.size() == HDR_WORDS + 2) begin
    checks += 3;
    if (got_words[4][15:0] !== 16'd36) begin
      errors++;
      $display("FAIL ip_total_len got %h expected %h", got_words[4][15:0], 16'd36);
    end
    if (got_words[10][31:16] !== 16'd16) begin
      errors++;
      $display("FAIL udp_len got %h expected %h", got_words[10][31:16], 16'd16);
    end
    if (got_words[6][15:0] !== ip_header_checksum(16'd36)) begin
      errors++;
      $display("FAIL ip_csum got %h expected %h", got_words[6][15:0],
               ip_header_checksum(16'd36));
    end
  end
endtask

task automatic stalled_frame();
  int busy;
  start_frame(16'd8, 16'h1234, 16'hABCD);
  rand_ready <= 1'b1;
  receive_frame(0, busy);
  rand_ready <= 1'b0;
  check_frame(16'd8, 16'h1234, 16'hABCD);
endtask

task automatic back_to_back_frames();
  int busy;
  start_frame(16'd4, 16'h0F0E, 16'h0D0C);
  receive_frame(5, busy);  // Request during frame
  check_frame(16'd4, 16'h0F0E, 16'h0D0C);
  check_frame_cycles(busy, HDR_WORDS + 1);
  expect_no_frame(GAP_CYCLES + 8);
  start_frame(16'd64, 16'h8001, 16'h7FFE);
  receive_frame(HDR_WORDS + 3, busy);
  check_frame(16'd64, 16'h8001, 16'h7FFE);
  check_frame_cycles(busy, HDR_WORDS + 16);
  expect_no_frame(GAP_CYCLES + 8);
endtask

`endif

//--- dv/tb_udp_sensor_tx.sv
`timescale 1ns/10ps

module tb_udp_sensor_tx;
  import udp_tx_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int INIT_TIMEOUT  = INIT_WAIT_CYCLES + 10 + 64 * (INIT_ENTRIES + 1);
  localparam int FRAME_TIMEOUT = 20 * (HDR_WORDS + 16);  // Largest frame under heavy stalls
  // Init plus four frames with setup and idle windows
  localparam int RUN_CYCLES    = INIT_TIMEOUT + 4 * (FRAME_TIMEOUT + 2 * (GAP_CYCLES + 8) + 20);

  logic      Clock_xCI = 1'b0;
  logic      rst_n;
  logic      send_packet;
  mtu_t      mtu;
  sample_t   speed_sample;
  sample_t   adc_sample;
  mm_addr_t  mm_address;
  logic      mm_write;
  mm_data_t  mm_writedata;
  logic      mm_waitrequest;
  st_data_t  st_data;
  logic      st_valid;
  logic      st_ready;
  logic      st_sop;
  logic      st_eop;
  st_empty_t st_empty;
  logic      init_done;

  int        seed = 67681;
  int        stall_rand;
  int        errors = 0;
  int        checks = 0;
  int        writes_seen = 0;      // Completed MM writes
  mm_write_t expected_write;
  logic      rand_ready = 1'b0;    // Random back-pressure on the stream
  logic      stalled = 1'b0;
  st_data_t  held_data;
  logic      held_sop;
  logic      held_eop;
  logic      early_valid = 1'b0;
  st_data_t  exp_words[$];
  st_data_t  got_words[$];
  logic [7:0] wire_bytes[$];       // Expected frame in wire order

  always #(CLK_PERIOD / 2) Clock_xCI = ~Clock_xCI;

  udp_sensor_tx dut_i (.*);

  // One random draw per cycle feeds both stall patterns
  always @(posedge Clock_xCI) begin
    stall_rand = $random(seed);
    mm_waitrequest <= stall_rand[0];
    st_ready       <= rand_ready ? stall_rand[1] : 1'b1;
  end

  // MM slave model and stream protocol monitor
  always @(posedge Clock_xCI) begin
    if (rst_n && mm_write && !mm_waitrequest) begin
      if (writes_seen > INIT_ENTRIES) begin
        errors++;
        $display("Unexpected write after the enable write, address %h", mm_address);
      end else begin
        expected_write = (writes_seen < INIT_ENTRIES) ? INIT_TABLE[writes_seen] : ENABLE_WRITE;
        checks += 2;
        if (mm_address !== expected_write[39:32]) begin
          errors++;
          $display("FAIL mm_address got %h expected %h", mm_address, expected_write[39:32]);
        end
        if (mm_writedata !== expected_write[31:0]) begin
          errors++;
          $display("FAIL mm_writedata got %h expected %h", mm_writedata, expected_write[31:0]);
        end
      end
      writes_seen++;
    end
    // Stalled word must stay put
    if (stalled && (!st_valid || st_data !== held_data || st_sop !== held_sop ||
                    st_eop !== held_eop)) begin
      errors++;
      $display("FAIL st_data during stall got %h expected %h", st_data, held_data);
    end
    stalled   = rst_n && st_valid && !st_ready;
    held_data = st_data;
    held_sop  = st_sop;
    held_eop  = st_eop;
    if (rst_n && st_valid && st_empty !== '0) begin
      errors++;
      $display("FAIL st_empty got %h expected %h", st_empty, 2'h0);
    end
    if (rst_n && st_valid && !init_done && !early_valid) begin
      early_valid = 1'b1;  // Report once
      errors++;
      $display("Stream went valid before init_done");
    end
  end

  `include "udp_tx_tests.svh"

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles with %0d errors", RUN_CYCLES, errors);
    $display("Checks failed");
    $finish;
  end

  initial begin
    rst_n          = 1'b0;
    send_packet    = 1'b0;
    mtu            = '0;
    speed_sample   = '0;
    adc_sample     = '0;
    mm_waitrequest = 1'b1;
    st_ready       = 1'b1;
    repeat (2) @(posedge Clock_xCI);
    rst_n <= 1'b1;
    verify_init_writes();
    single_frame_ready_high();
    stalled_frame();
    back_to_back_frames();
    repeat (4) @(posedge Clock_xCI);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- logic/avalon_mm_if.sv
`timescale 1ns/10ps

// Write-only Avalon-MM link to the MAC control port
interface avalon_mm_if;
  import udp_tx_pkg::*;

  mm_addr_t address;
  logic     write;
  mm_data_t writedata;
  logic     waitrequest;  // High stalls the current write

  modport master (
    output address, write, writedata,
    input  waitrequest
  );

  modport slave (
    input  address, write, writedata,
    output waitrequest
  );

endinterface

//--- logic/avalon_st_if.sv
`timescale 1ns/10ps

// Avalon-ST packet stream, ready latency 0
interface avalon_st_if;
  import udp_tx_pkg::*;

  st_data_t  data;
  logic      valid;
  logic      ready;
  logic      sop;    // First word of frame
  logic      eop;    // Last word of frame
  st_empty_t empty;  // Frames are whole words here

  modport source (
    output data, valid, sop, eop, empty,
    input  ready
  );

  modport sink (
    input  data, valid, sop, eop, empty,
    output ready
  );

endinterface

//--- logic/frame_header_gen.sv
`timescale 1ns/10ps

module frame_header_gen (
  input  logic                   Clock_xCI,
  input  logic                   rst_n,
  input  udp_tx_pkg::mtu_t       mtu,
  input  udp_tx_pkg::hdr_index_t word_index,
  output udp_tx_pkg::st_data_t   hdr_word
);
  import udp_tx_pkg::*;

  len_t     ip_total_len;  // IP header + UDP header + payload
  len_t     udp_len;       // UDP header + payload
  csum_t    ip_csum;
  st_data_t hdr_words [HDR_WORDS];

  always_ff @(posedge Clock_xCI) begin
    ip_total_len <= len_t'(mtu) + len_t'(IP_HDR_BYTES + UDP_HDR_BYTES);
    udp_len      <= len_t'(mtu) + len_t'(UDP_HDR_BYTES);
  end

  // Checksum trails the length by six cycles
  ip_checksum u_ip_checksum (
    .Clock_xCI (Clock_xCI),
    .rst_n     (rst_n),
    .total_len (ip_total_len),
    .checksum  (ip_csum)
  );

  // Words in wire order, first byte in low lane
  always_comb begin
    for (int i = 0; i < LINK_WORDS; i++) begin
      hdr_words[i] = LINK_HEADER_WORDS[i];
    end
    hdr_words[LINK_WORDS + 0] = pack_le(IP_VER_TOS, ip_total_len);
    hdr_words[LINK_WORDS + 1] = pack_le(IP_ID, IP_FLAGS);
    hdr_words[LINK_WORDS + 2] = pack_le(IP_TTL_PROTO, ip_csum);
    hdr_words[LINK_WORDS + 3] = pack_le(IP_SRC_HI, IP_SRC_LO);
    hdr_words[LINK_WORDS + 4] = pack_le(IP_DST_HI, IP_DST_LO);
    // UDP checksum zero, i.e. not used
    hdr_words[LINK_WORDS + IP_WORDS + 0] = pack_le(UDP_SRC_PORT, UDP_DST_PORT);
    hdr_words[LINK_WORDS + IP_WORDS + 1] = pack_le(udp_len, 16'h0000);
  end

  assign hdr_word = hdr_words[word_index];

  // Sequencer never points past the header
  a_index_range: assert property (@(posedge Clock_xCI) disable iff (!rst_n)
    word_index < HDR_WORDS);

endmodule

//--- logic/frame_tx_fsm.sv
`timescale 1ns/10ps

module frame_tx_fsm (
  input  logic                   Clock_xCI,
  input  logic                   rst_n,
  input  logic                   init_done,
  input  logic                   send_packet,
  input  udp_tx_pkg::mtu_t       mtu,
  input  udp_tx_pkg::sample_t    speed_sample,
  input  udp_tx_pkg::sample_t    adc_sample,
  output udp_tx_pkg::hdr_index_t word_index,
  input  udp_tx_pkg::st_data_t   hdr_word,
  avalon_st_if.source            st
);
  import udp_tx_pkg::*;

  tx_state_t  state;
  logic       send_q;     // Registered request
  sample_t    speed_q;
  sample_t    adc_q;
  hdr_index_t idx;        // Next header word to load
  mtu_t       pay_cnt;    // Payload words loaded so far
  mtu_t       pay_words;
  logic [$clog2(GAP_CYCLES+1)-1:0] gap_cnt;
  st_data_t   data_q;     // Output word before swap
  logic       valid_q;
  logic       sop_q;
  logic       eop_q;
  logic       advance;    // Output slot free for a new word

  assign pay_words = mtu >> 2;
  assign advance   = !valid_q || st.ready;

  always_ff @(posedge Clock_xCI) begin
    speed_q <= speed_sample;
    adc_q   <= adc_sample;
  end

  always_ff @(posedge Clock_xCI) begin
    if (!rst_n) begin
      state   <= idle;
      send_q  <= 1'b0;
      idx     <= '0;
      pay_cnt <= '0;
      gap_cnt <= '0;
      valid_q <= 1'b0;
      sop_q   <= 1'b0;
      eop_q   <= 1'b0;
    end else begin
      send_q <= send_packet;
      case (state)
        idle: begin
          // Requests outside idle are dropped
          if (init_done && send_q) begin
            data_q  <= hdr_word;  // idx is 0 here
            valid_q <= 1'b1;
            sop_q   <= 1'b1;
            idx     <= idx + 1'b1;
            state   <= send_header;
          end
        end
        send_header: begin
          if (advance) begin
            data_q <= hdr_word;
            sop_q  <= 1'b0;
            if (idx == HDR_WORDS - 1) begin
              idx     <= '0;
              pay_cnt <= '0;
              state   <= send_payload;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        send_payload: begin
          if (advance) begin
            if (eop_q) begin
              // Last word just went out
              valid_q <= 1'b0;
              eop_q   <= 1'b0;
              gap_cnt <= '0;
              state   <= gap;
            end else begin
              data_q  <= {speed_q, adc_q};
              pay_cnt <= pay_cnt + 1'b1;
              eop_q   <= (pay_cnt == pay_words - 1'b1);
            end
          end
        end
        default: begin  // Inter-packet gap
          if (gap_cnt < GAP_CYCLES) gap_cnt <= gap_cnt + 1'b1;
          else state <= idle;
        end
      endcase
    end
  end

  assign word_index = idx;
  assign st.data    = byte_swap(data_q);  // MAC takes first byte in MSBs
  assign st.valid   = valid_q;
  assign st.sop     = sop_q;
  assign st.eop     = eop_q;
  assign st.empty   = '0;

  // Stalled word stays on the bus unchanged
  a_st_hold: assert property (@(posedge Clock_xCI) disable iff (!rst_n)
    st.valid && !st.ready |=> st.valid && $stable(st.data) && $stable(st.sop) &&
                              $stable(st.eop));

endmodule

//--- logic/ip_checksum.sv
`timescale 1ns/10ps

module ip_checksum (
  input  logic              Clock_xCI,
  input  logic              rst_n,
  input  udp_tx_pkg::len_t  total_len,
  output udp_tx_pkg::csum_t checksum
);
  import udp_tx_pkg::*;

  logic [16:0] s1_a, s1_b, s1_c, s1_d;  // Pairwise sums
  logic [17:0] s2_a, s2_b;
  logic [18:0] s3;
  logic [19:0] s4;                      // All nine halfwords
  logic [16:0] s5;                      // First carry fold

  always_ff @(posedge Clock_xCI) begin
    if (!rst_n) begin
      s1_a     <= '0;
      s1_b     <= '0;
      s1_c     <= '0;
      s1_d     <= '0;
      s2_a     <= '0;
      s2_b     <= '0;
      s3       <= '0;
      s4       <= '0;
      s5       <= '0;
      checksum <= '0;
    end else begin
      // Stage 1, only the length varies
      s1_a <= total_len + IP_VER_TOS;
      s1_b <= IP_ID + IP_FLAGS;
      s1_c <= IP_TTL_PROTO + IP_SRC_HI;
      s1_d <= IP_SRC_LO + IP_DST_HI;
      s2_a <= s1_a + s1_b;
      s2_b <= s1_c + s1_d;
      s3   <= s2_a + s2_b;
      s4   <= s3 + IP_DST_LO;                  // Odd word joins late
      s5   <= s4[19:16] + s4[15:0];
      checksum <= ~(s5[15:0] + s5[16]);        // Second fold cannot carry
    end
  end

endmodule

//--- logic/mac_init_master.sv
`timescale 1ns/10ps

module mac_init_master (
  input  logic        Clock_xCI,
  input  logic        rst_n,
  avalon_mm_if.master mm,
  output logic        init_done
);
  import udp_tx_pkg::*;

  init_state_t state;
  logic [$clog2(INIT_WAIT_CYCLES+1)-1:0] wait_cnt;  // Post-reset settle count
  logic [$clog2(INIT_ENTRIES)-1:0]       entry_idx;  // Current table row
  mm_write_t entry;

  assign entry = INIT_TABLE[entry_idx];

  // Address and data registers, written only when a write is launched
  always_ff @(posedge Clock_xCI) begin
    if (state == write_req) begin
      mm.address   <= entry[$bits(mm_data_t) +: $bits(mm_addr_t)];
      mm.writedata <= entry[$bits(mm_data_t)-1:0];
    end else if (state == enable_req) begin
      mm.address   <= ENABLE_WRITE[$bits(mm_data_t) +: $bits(mm_addr_t)];
      mm.writedata <= ENABLE_WRITE[$bits(mm_data_t)-1:0];
    end
  end

  always_ff @(posedge Clock_xCI) begin
    if (!rst_n) begin
      state     <= wait_init;
      wait_cnt  <= '0;
      entry_idx <= '0;
      mm.write  <= 1'b0;
    end else begin
      case (state)
        wait_init: begin
          if (wait_cnt < INIT_WAIT_CYCLES) wait_cnt <= wait_cnt + 1'b1;
          else state <= write_req;
        end
        write_req: begin
          mm.write <= 1'b1;
          state    <= write_wait;
        end
        write_wait: begin
          // Slave takes the write in the first cycle without waitrequest
          if (!mm.waitrequest) begin
            mm.write <= 1'b0;
            state    <= next_entry;
          end
        end
        next_entry: begin
          if (entry_idx == INIT_ENTRIES - 1) begin
            state <= enable_req;
          end else begin
            entry_idx <= entry_idx + 1'b1;
            state     <= write_req;
          end
        end
        enable_req: begin
          mm.write <= 1'b1;  // Final write turns on TX and RX
          state    <= enable_wait;
        end
        enable_wait: begin
          if (!mm.waitrequest) begin
            mm.write <= 1'b0;
            state    <= done;
          end
        end
        default: state <= done;  // Done holds forever
      endcase
    end
  end

  assign init_done = (state == done);

  // A stalled write keeps its address and data until accepted
  a_mm_hold: assert property (@(posedge Clock_xCI) disable iff (!rst_n)
    mm.write && mm.waitrequest |=> mm.write && $stable(mm.address) && $stable(mm.writedata));

endmodule

//--- logic/udp_sensor_tx.sv
`timescale 1ns/10ps

module udp_sensor_tx (
  input  logic                  Clock_xCI,
  input  logic                  rst_n,
  input  logic                  send_packet,
  input  udp_tx_pkg::mtu_t      mtu,
  input  udp_tx_pkg::sample_t   speed_sample,
  input  udp_tx_pkg::sample_t   adc_sample,
  output udp_tx_pkg::mm_addr_t  mm_address,
  output logic                  mm_write,
  output udp_tx_pkg::mm_data_t  mm_writedata,
  input  logic                  mm_waitrequest,
  output udp_tx_pkg::st_data_t  st_data,
  output logic                  st_valid,
  input  logic                  st_ready,
  output logic                  st_sop,
  output logic                  st_eop,
  output udp_tx_pkg::st_empty_t st_empty,
  output logic                  init_done
);
  import udp_tx_pkg::*;

  hdr_index_t word_index;
  st_data_t   hdr_word;

  avalon_mm_if mm_bus ();
  avalon_st_if st_bus ();

  // MAC control port
  assign mm_address       = mm_bus.address;
  assign mm_write         = mm_bus.write;
  assign mm_writedata     = mm_bus.writedata;
  assign mm_bus.waitrequest = mm_waitrequest;

  // MAC TX stream
  assign st_data      = st_bus.data;
  assign st_valid     = st_bus.valid;
  assign st_sop       = st_bus.sop;
  assign st_eop       = st_bus.eop;
  assign st_empty     = st_bus.empty;
  assign st_bus.ready = st_ready;

  mac_init_master u_mac_init_master (
    .Clock_xCI (Clock_xCI),
    .rst_n     (rst_n),
    .mm        (mm_bus.master),
    .init_done (init_done)
  );

  frame_header_gen u_frame_header_gen (
    .Clock_xCI  (Clock_xCI),
    .rst_n      (rst_n),
    .mtu        (mtu),
    .word_index (word_index),
    .hdr_word   (hdr_word)
  );

  frame_tx_fsm u_frame_tx_fsm (
    .Clock_xCI    (Clock_xCI),
    .rst_n        (rst_n),
    .init_done    (init_done),
    .send_packet  (send_packet),
    .mtu          (mtu),
    .speed_sample (speed_sample),
    .adc_sample   (adc_sample),
    .word_index   (word_index),
    .hdr_word     (hdr_word),
    .st           (st_bus.source)
  );

endmodule

//--- logic/udp_tx_pkg.sv
package udp_tx_pkg;

  // Bus and field widths
  typedef logic [31:0] st_data_t;    // One stream word
  typedef logic [1:0]  st_empty_t;   // Empty bytes in last word
  typedef logic [7:0]  mm_addr_t;    // MAC register address
  typedef logic [31:0] mm_data_t;    // MAC register value
  typedef logic [39:0] mm_write_t;   // Address in top byte, data below
  typedef logic [15:0] mtu_t;        // Payload bytes
  typedef logic [15:0] sample_t;     // Sensor or ADC sample
  typedef logic [15:0] len_t;
  typedef logic [15:0] csum_t;
  typedef logic [3:0]  hdr_index_t;  // Header word 0..10

  typedef enum logic [2:0] {
    wait_init, write_req, write_wait, next_entry, enable_req, enable_wait, done
  } init_state_t;

  typedef enum logic [1:0] {
    idle, send_header, send_payload, gap
  } tx_state_t;

  // Header word counts
  localparam int LINK_WORDS = 4;
  localparam int IP_WORDS   = 5;
  localparam int UDP_WORDS  = 2;
  localparam int HDR_WORDS  = LINK_WORDS + IP_WORDS + UDP_WORDS;

  localparam int IP_HDR_BYTES  = 20;
  localparam int UDP_HDR_BYTES = 8;

  localparam int INIT_WAIT_CYCLES = 5;
  localparam int GAP_CYCLES       = 5;

  // MAC address, PHY addresses, PHY setup, PHY soft reset
  localparam int INIT_ENTRIES = 8;
  localparam mm_write_t [0:INIT_ENTRIES-1] INIT_TABLE = {
    40'h03_b5ed5354, 40'h04_0000aa2d, 40'h0F_00000010, 40'h10_00000011,
    40'h94_00004000, 40'hB0_00000078, 40'hB4_00000ce2, 40'hA0_00009140
  };
  localparam mm_write_t ENABLE_WRITE = 40'h02_00000043;  // TX, RX and CRC forwarding

  // Link words kept with the first wire byte in the low lane
  localparam st_data_t [0:LINK_WORDS-1] LINK_HEADER_WORDS = {
    32'h0001_0000, 32'h0101_015e, 32'hb5ed_5354, 32'h0008_aa2d
  };

  // Fixed IPv4 fields, wire order
  localparam logic [15:0] IP_VER_TOS   = 16'h4500;
  localparam logic [15:0] IP_ID        = 16'hB9A3;
  localparam logic [15:0] IP_FLAGS     = 16'h4000;  // Don't fragment
  localparam logic [15:0] IP_TTL_PROTO = 16'h0111;  // TTL 1, UDP
  localparam logic [15:0] IP_SRC_HI    = 16'hC0A8;
  localparam logic [15:0] IP_SRC_LO    = 16'h0A02;
  localparam logic [15:0] IP_DST_HI    = 16'hEF01;
  localparam logic [15:0] IP_DST_LO    = 16'h0101;

  localparam logic [15:0] UDP_SRC_PORT = 16'hBE98;
  localparam logic [15:0] UDP_DST_PORT = 16'h2382;

  // Reverse byte lanes of a word
  function automatic st_data_t byte_swap(input st_data_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Two wire-order halfwords into one pre-swap word
  function automatic st_data_t pack_le(input logic [15:0] first, input logic [15:0] second);
    return byte_swap({first, second});
  endfunction

endpackage

//--- udp_sensor_tx.f
+incdir+include
logic/udp_tx_pkg.sv
logic/avalon_mm_if.sv
logic/avalon_st_if.sv
logic/mac_init_master.sv
logic/ip_checksum.sv
logic/frame_header_gen.sv
logic/frame_tx_fsm.sv
logic/udp_sensor_tx.sv
dv/tb_udp_sensor_tx.sv
